//--- src/tau_pkg.sv
package tau_pkg;

    // Number of fractional bits in every Q2.16 sample
    localparam int FRAC_BITS = 16;

    // Signed Q2.16 sample, covering -2.0 up to just below +2.0
    typedef logic signed [17:0] sample_t;

    // Rotor angle as an unsigned fraction of one full electrical turn
    typedef logic [15:0] angle_t;

    // Wide signed accumulator for Q.32 products and their sums
    typedef logic signed [47:0] acc_t;

    // Phase c sits in the top bits and phase a in the bottom bits
    typedef struct packed {
        sample_t c;
        sample_t b;
        sample_t a;
    } abc_frame_t;

    // Stationary frame, alpha in the low half
    typedef struct packed {
        sample_t beta;
        sample_t alpha;
    } ab_frame_t;

    // Rotating frame, d in the low half
    typedef struct packed {
        sample_t q;
        sample_t d;
    } dq_frame_t;

    // Request driven by the bus master, one access per cycle
    typedef struct packed {
        logic        write_strobe;
        logic        read_strobe;
        logic [31:0] address;
        logic [31:0] write_data;
    } sb_req_t;

    // Response returned by the register block one cycle after a read
    typedef struct packed {
        logic        read_valid;
        logic [31:0] read_data;
    } sb_rsp_t;

    // Bit 1 disables the inverse chain and bit 0 disables the direct chain
    typedef struct packed {
        logic inverse_chain_disable;
        logic direct_chain_disable;
    } control_reg_t;

    // Byte offsets of the registers from the block base address
    typedef enum logic [31:0] {
        REG_CONTROL    = 32'h0000_0000,
        REG_SOFT_RESET = 32'h0000_0004
    } reg_offset_e;

    localparam logic [31:0] TAU_BASE_ADDRESS = 32'h43C0_0000;
    // Span of the block in bytes, offsets past the last register read as zero
    localparam logic [31:0] TAU_BLOCK_BYTES = 32'h0000_0010;

    // Saturation limits of sample_t
    localparam sample_t SAMPLE_MAX = 18'sh1FFFF;
    localparam sample_t SAMPLE_MIN = 18'sh20000;

    // Transform coefficients rounded to Q2.16
    localparam sample_t ONE_THIRD_Q  = 18'sd21845;
    localparam sample_t INV_SQRT3_Q  = 18'sd37837;
    localparam sample_t HALF_SQRT3_Q = 18'sd56756;

    // The sine table is indexed by the top angle bits only
    localparam int LUT_INDEX_BITS = 8;
    localparam int LUT_DEPTH = 1 << LUT_INDEX_BITS;
    localparam logic [LUT_INDEX_BITS-1:0] LUT_QUARTER_TURN = LUT_INDEX_BITS'(LUT_DEPTH / 4);

    // Rounds a Q.32 accumulator to the nearest Q2.16 value and clamps it
    function automatic sample_t round_sat(input acc_t acc);
        acc_t rounded;
        rounded = (acc + (acc_t'(1) <<< (FRAC_BITS - 1))) >>> FRAC_BITS;
        if (rounded > acc_t'(SAMPLE_MAX)) begin
            return SAMPLE_MAX;
        end
        if (rounded < acc_t'(SAMPLE_MIN)) begin
            return SAMPLE_MIN;
        end
        return rounded[17:0];
    endfunction

endpackage

//--- src/clarke.sv
`timescale 1ns/1ns

module clarke (
    input  tau_pkg::abc_frame_t in,
    output tau_pkg::ab_frame_t  out
);

    // Weighted phase sums before scaling, wide enough to never overflow
    tau_pkg::acc_t alpha_sum;
    tau_pkg::acc_t beta_sum;

    // Scaled results in Q.32, still carrying all fractional bits
    tau_pkg::acc_t alpha_acc;
    tau_pkg::acc_t beta_acc;

    // Amplitude invariant form, alpha gets two thirds of a minus the mean of b and c
    assign alpha_sum = (tau_pkg::acc_t'(in.a) <<< 1) - tau_pkg::acc_t'(in.b)
                     - tau_pkg::acc_t'(in.c);

    // Beta only depends on the difference of the two trailing phases
    assign beta_sum = tau_pkg::acc_t'(in.b) - tau_pkg::acc_t'(in.c);

    // Q2.16 sum times Q2.16 constant lands in Q.32
    assign alpha_acc = alpha_sum * tau_pkg::acc_t'(tau_pkg::ONE_THIRD_Q);
    assign beta_acc  = beta_sum * tau_pkg::acc_t'(tau_pkg::INV_SQRT3_Q);

    // Back to Q2.16 with rounding, clamped at the format limits
    assign out.alpha = tau_pkg::round_sat(alpha_acc);
    assign out.beta  = tau_pkg::round_sat(beta_acc);

endmodule

//--- src/anti_clarke.sv
`timescale 1ns/1ns

module anti_clarke (
    input  tau_pkg::ab_frame_t  in,
    output tau_pkg::abc_frame_t out
);

    // Alpha moved into the Q.32 domain so it lines up with the products
    tau_pkg::acc_t alpha_full;
    tau_pkg::acc_t alpha_half;

    // The sqrt(3)/2 weighted beta term is shared by phases b and c
    tau_pkg::acc_t beta_term;

    tau_pkg::acc_t b_acc;
    tau_pkg::acc_t c_acc;

    // One shift less gives half of alpha without any rounding loss
    assign alpha_full = tau_pkg::acc_t'(in.alpha) <<< tau_pkg::FRAC_BITS;
    assign alpha_half = tau_pkg::acc_t'(in.alpha) <<< (tau_pkg::FRAC_BITS - 1);

    assign beta_term = tau_pkg::acc_t'(in.beta) * tau_pkg::acc_t'(tau_pkg::HALF_SQRT3_Q);

    // Phases b and c are placed 120 degrees either side of phase a
    assign b_acc = beta_term - alpha_half;
    assign c_acc = -alpha_half - beta_term;

    // Phase a is alpha itself, passed through the same output stage
    assign out.a = tau_pkg::round_sat(alpha_full);
    assign out.b = tau_pkg::round_sat(b_acc);
    assign out.c = tau_pkg::round_sat(c_acc);

endmodule

//--- src/sin_cos_lut.sv
`timescale 1ns/1ns

module sin_cos_lut (
    input  logic             clock,
    input  logic             rst_n,
    input  logic             clear,
    input  tau_pkg::angle_t  theta,
    output tau_pkg::sample_t sin_out,
    output tau_pkg::sample_t cos_out
);

    // One full turn of sine, one entry per table step
    tau_pkg::sample_t sine_table [tau_pkg::LUT_DEPTH];

    logic [tau_pkg::LUT_INDEX_BITS-1:0] sin_index;
    logic [tau_pkg::LUT_INDEX_BITS-1:0] cos_index;

    // Only the top angle bits select an entry, the rest are dropped
    assign sin_index = theta[$bits(tau_pkg::angle_t)-1 -: tau_pkg::LUT_INDEX_BITS];

    // Cosine leads sine by a quarter turn, the index wraps around naturally
    assign cos_index = sin_index + tau_pkg::LUT_QUARTER_TURN;

    // Table contents are computed once when simulation starts
    initial begin
        real phase;
        real scale;
        scale = 2.0 ** tau_pkg::FRAC_BITS;
        for (int i = 0; i < tau_pkg::LUT_DEPTH; i++) begin
            phase = 2.0 * 3.14159265358979 * i / tau_pkg::LUT_DEPTH;
            // Round to nearest, the peak of 1.0 still fits in Q2.16
            sine_table[i] = tau_pkg::sample_t'($rtoi($floor($sin(phase) * scale + 0.5)));
        end
    end

    // Registered lookup forms the first pipeline stage of the rotations
    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            sin_out <= '0;
            cos_out <= '0;
        end else if (clear) begin
            sin_out <= '0;
            cos_out <= '0;
        end else begin
            sin_out <= sine_table[sin_index];
            cos_out <= sine_table[cos_index];
        end
    end

endmodule

//--- src/park.sv
`timescale 1ns/1ns

module park (
    input  logic               clock,
    input  logic               rst_n,
    input  logic               clear,
    input  tau_pkg::angle_t    theta,
    input  tau_pkg::ab_frame_t in,
    output tau_pkg::dq_frame_t out
);

    // Sine and cosine of theta, valid one cycle after theta
    tau_pkg::sample_t sin_theta;
    tau_pkg::sample_t cos_theta;

    // Stage one copy of the input so it meets the table output
    tau_pkg::ab_frame_t ab_q;

    // Rotation sums in Q.32 ahead of the output register
    tau_pkg::acc_t d_acc;
    tau_pkg::acc_t q_acc;

    sin_cos_lut lut (
        .clock  (clock),
        .rst_n  (rst_n),
        .clear  (clear),
        .theta  (theta),
        .sin_out(sin_theta),
        .cos_out(cos_theta)
    );

    // Stage one, aligned with the registered table lookup
    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            ab_q <= '0;
        end else if (clear) begin
            ab_q <= '0;
        end else begin
            ab_q <= in;
        end
    end

    // Rotate the stationary frame by minus theta into the rotor frame
    assign d_acc = tau_pkg::acc_t'(ab_q.alpha) * tau_pkg::acc_t'(cos_theta)
                 + tau_pkg::acc_t'(ab_q.beta) * tau_pkg::acc_t'(sin_theta);
    assign q_acc = tau_pkg::acc_t'(ab_q.beta) * tau_pkg::acc_t'(cos_theta)
                 - tau_pkg::acc_t'(ab_q.alpha) * tau_pkg::acc_t'(sin_theta);

    // Stage two holds the rounded and clamped result
    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            out <= '0;
        end else if (clear) begin
            out <= '0;
        end else begin
            out.d <= tau_pkg::round_sat(d_acc);
            out.q <= tau_pkg::round_sat(q_acc);
        end
    end

endmodule

//--- src/anti_park.sv
`timescale 1ns/1ns

module anti_park (
    input  logic               clock,
    input  logic               rst_n,
    input  logic               clear,
    input  tau_pkg::angle_t    theta,
    input  tau_pkg::dq_frame_t in,
    output tau_pkg::ab_frame_t out
);

    // Table outputs share the latency of the input register below
    tau_pkg::sample_t sin_theta;
    tau_pkg::sample_t cos_theta;

    // Rotor frame sample held for one cycle
    tau_pkg::dq_frame_t dq_q;

    tau_pkg::acc_t alpha_acc;
    tau_pkg::acc_t beta_acc;

    sin_cos_lut lut (
        .clock  (clock),
        .rst_n  (rst_n),
        .clear  (clear),
        .theta  (theta),
        .sin_out(sin_theta),
        .cos_out(cos_theta)
    );

    // Stage one, same timing as the lookup so both reach stage two together
    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            dq_q <= '0;
        end else if (clear) begin
            dq_q <= '0;
        end else begin
            dq_q <= in;
        end
    end

    // Rotate back by plus theta into the stationary frame
    assign alpha_acc = tau_pkg::acc_t'(dq_q.d) * tau_pkg::acc_t'(cos_theta)
                     - tau_pkg::acc_t'(dq_q.q) * tau_pkg::acc_t'(sin_theta);
    assign beta_acc  = tau_pkg::acc_t'(dq_q.d) * tau_pkg::acc_t'(sin_theta)
                     + tau_pkg::acc_t'(dq_q.q) * tau_pkg::acc_t'(cos_theta);

    // Stage two output register
    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            out <= '0;
        end else if (clear) begin
            out <= '0;
        end else begin
            out.alpha <= tau_pkg::round_sat(alpha_acc);
            out.beta  <= tau_pkg::round_sat(beta_acc);
        end
    end

endmodule

//--- src/tau_control_unit.sv
`timescale 1ns/1ns

module tau_control_unit (
    input  logic             clock,
    input  logic             rst_n,
    input  tau_pkg::sb_req_t sb_req,
    output tau_pkg::sb_rsp_t sb_rsp,
    output logic             direct_chain_disable,
    output logic             inverse_chain_disable,
    output logic             soft_reset
);

    // Offset of the current access relative to the block base
    logic [31:0] offset;
    logic        in_block;
    tau_pkg::reg_offset_e reg_sel;

    logic control_write;
    logic soft_reset_write;
    logic read_hit;

    tau_pkg::control_reg_t control;

    // Registered read response
    logic        read_valid;
    logic [31:0] read_data;

    // Addresses below the base wrap to a large offset and so fall outside too
    assign offset   = sb_req.address - tau_pkg::TAU_BASE_ADDRESS;
    assign in_block = offset < tau_pkg::TAU_BLOCK_BYTES;
    assign reg_sel  = tau_pkg::reg_offset_e'(offset);

    assign control_write = sb_req.write_strobe && in_block
                         && (reg_sel == tau_pkg::REG_CONTROL);
    // Only a 1 in bit 0 triggers the soft reset, other values are ignored
    assign soft_reset_write = sb_req.write_strobe && in_block
                            && (reg_sel == tau_pkg::REG_SOFT_RESET) && sb_req.write_data[0];
    assign read_hit = sb_req.read_strobe && in_block;

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            control    <= '0;
            soft_reset <= 1'b0;
            read_valid <= 1'b0;
        end else begin
            if (control_write) begin
                control <= tau_pkg::control_reg_t'(sb_req.write_data[1:0]);
            end
            // Self clearing, high for exactly the cycle after the write
            soft_reset <= soft_reset_write;
            read_valid <= read_hit;
        end
    end

    // Every offset apart from the control register reads back as zero
    always_ff @(posedge clock) begin
        if (read_hit) begin
            read_data <= (reg_sel == tau_pkg::REG_CONTROL) ? {30'b0, control} : 32'b0;
        end
    end

    assign sb_rsp.read_valid = read_valid;
    assign sb_rsp.read_data  = read_data;

    assign direct_chain_disable  = control.direct_chain_disable;
    assign inverse_chain_disable = control.inverse_chain_disable;

endmodule

//--- src/transform_accel_unit.sv
`timescale 1ns/1ns

module transform_accel_unit (
    input  logic                clock,
    input  logic                rst_n,
    input  tau_pkg::sb_req_t    sb_req,
    output tau_pkg::sb_rsp_t    sb_rsp,
    input  tau_pkg::angle_t     theta,
    input  tau_pkg::abc_frame_t clarke_in,
    output tau_pkg::ab_frame_t  clarke_out,
    input  tau_pkg::ab_frame_t  park_in,
    output tau_pkg::dq_frame_t  park_out,
    input  tau_pkg::dq_frame_t  inverse_park_in,
    output tau_pkg::ab_frame_t  inverse_park_out,
    input  tau_pkg::ab_frame_t  inverse_clarke_in,
    output tau_pkg::abc_frame_t inverse_clarke_out
);

    logic direct_chain_disable;
    logic inverse_chain_disable;
    logic soft_reset;

    // Inputs actually seen by the Park and inverse Clarke stages
    tau_pkg::ab_frame_t park_selected_in;
    tau_pkg::ab_frame_t anti_clarke_selected_in;

    // With a chain disabled the stage takes its external input instead
    assign park_selected_in = direct_chain_disable ? park_in : clarke_out;
    assign anti_clarke_selected_in = inverse_chain_disable ? inverse_clarke_in
                                                           : inverse_park_out;

    tau_control_unit control_unit (
        .clock                (clock),
        .rst_n                (rst_n),
        .sb_req               (sb_req),
        .sb_rsp               (sb_rsp),
        .direct_chain_disable (direct_chain_disable),
        .inverse_chain_disable(inverse_chain_disable),
        .soft_reset           (soft_reset)
    );

    clarke clarke_stage (
        .in (clarke_in),
        .out(clarke_out)
    );

    // Soft reset flushes both rotation pipelines but leaves the registers alone
    park park_stage (
        .clock(clock),
        .rst_n(rst_n),
        .clear(soft_reset),
        .theta(theta),
        .in   (park_selected_in),
        .out  (park_out)
    );

    anti_park anti_park_stage (
        .clock(clock),
        .rst_n(rst_n),
        .clear(soft_reset),
        .theta(theta),
        .in   (inverse_park_in),
        .out  (inverse_park_out)
    );

    anti_clarke anti_clarke_stage (
        .in (anti_clarke_selected_in),
        .out(inverse_clarke_out)
    );

endmodule

//--- tb/tau_checker.sv
`timescale 1ns/1ns

module tau_checker (
    input logic                clock,
    input logic                rst_n,
    input tau_pkg::sb_req_t    sb_req,
    input tau_pkg::sb_rsp_t    sb_rsp,
    input tau_pkg::dq_frame_t  park_out,
    input tau_pkg::ab_frame_t  inverse_park_out,
    input logic                direct_chain_disable,
    input logic                inverse_chain_disable,
    input logic                soft_reset
);

    // Count of failed assertions, watched from the testbench top
    int failures = 0;

    // A read strobe that lands on any offset of the register block
    logic read_in_block;

    assign read_in_block = sb_req.read_strobe
        && ((sb_req.address - tau_pkg::TAU_BASE_ADDRESS) < tau_pkg::TAU_BLOCK_BYTES);

    // While rst_n is low every register output must already be cleared
    reset_clears_outputs: assert property (@(posedge clock)
        !rst_n |-> (park_out == '0 && inverse_park_out == '0 && !direct_chain_disable
                    && !inverse_chain_disable && !soft_reset && !sb_rsp.read_valid))
    else begin
        $error("outputs or control bits not cleared during reset");
        failures++;
    end

    // Read-valid is the registered image of a read strobe inside the block
    read_gives_valid: assert property (@(posedge clock) disable iff (!rst_n)
        read_in_block |=> sb_rsp.read_valid)
    else begin
        $error("read inside the block gave no read-valid one cycle later");
        failures++;
    end

    no_read_no_valid: assert property (@(posedge clock) disable iff (!rst_n)
        !read_in_block |=> !sb_rsp.read_valid)
    else begin
        $error("read-valid without a read strobe inside the block");
        failures++;
    end

    // The soft reset pulse flushes both rotation pipelines on the next edge
    soft_reset_flushes: assert property (@(posedge clock) disable iff (!rst_n)
        soft_reset |=> (park_out == '0 && inverse_park_out == '0))
    else begin
        $error("rotation outputs not zero one cycle after soft reset");
        failures++;
    end

endmodule

//--- tb/tau_tb.sv
`timescale 1ns/1ns

module tau_tb;

    logic                clock;
    logic                rst_n;
    tau_pkg::sb_req_t    sb_req;
    tau_pkg::sb_rsp_t    sb_rsp;
    tau_pkg::angle_t     theta;
    tau_pkg::abc_frame_t clarke_in;
    tau_pkg::ab_frame_t  clarke_out;
    tau_pkg::ab_frame_t  park_in;
    tau_pkg::dq_frame_t  park_out;
    tau_pkg::dq_frame_t  inverse_park_in;
    tau_pkg::ab_frame_t  inverse_park_out;
    tau_pkg::ab_frame_t  inverse_clarke_in;
    tau_pkg::abc_frame_t inverse_clarke_out;

    // Chain disable bits as last written over the bus
    logic        direct_off;
    logic        inverse_off;
    logic [31:0] rng_state = 32'd2;
    int          cycle_count = 0;
    int          vectors_per_test = 12;
    int          test_count = 5;
    real         pi = 3.14159265358979;
    logic [31:0] base = tau_pkg::TAU_BASE_ADDRESS;

    // Expected rotation results kept in one slot per cycle and due two cycles after the drive
    real exp_d [4];
    real exp_q [4];
    real exp_a [4];
    real exp_beta [4];
    real exp_b [4];
    real exp_c [4];
    bit  park_due [4];
    bit  chain_due [4];

    transform_accel_unit dut (.*);

    bind transform_accel_unit tau_checker checks (.*);

    initial begin
        clock = 1'b0;
        forever #10 clock = ~clock;
    end

    // Generous allowance per vector on top of reset and bus traffic
    initial begin
        repeat (40 * vectors_per_test * test_count + 200) @(posedge clock);
        $display("watchdog expired before the tests completed");
        fail_run();
    end

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic real q2r(input tau_pkg::sample_t s);
        return $itor(s) / 65536.0;
    endfunction

    function automatic real clarke_alpha(input real a, input real b, input real c);
        return (2.0 * a - b - c) / 3.0;
    endfunction

    function automatic real clarke_beta(input real b, input real c);
        return (b - c) / $sqrt(3.0);
    endfunction

    // Inverse Clarke phases b and c, as phase a is simply alpha
    function automatic real phase_b(input real alpha, input real beta);
        return -0.5 * alpha + 0.5 * $sqrt(3.0) * beta;
    endfunction

    function automatic real phase_c(input real alpha, input real beta);
        return -0.5 * alpha - 0.5 * $sqrt(3.0) * beta;
    endfunction

    task automatic fail_run();
        $display("** FAIL **");
        $fatal(1);
    endtask

    // Tolerance of 4 LSB covers table quantization and the rounding of each stage
    task automatic check_near(input string name, input tau_pkg::sample_t got, input real want);
        real diff;
        diff = $itor(got) - want * 65536.0;
        assert (diff <= 4.0 && diff >= -4.0) else begin
            $display("mismatch %s: got %h expected %h", name, got,
                     tau_pkg::sample_t'($rtoi(want * 65536.0)));
            fail_run();
        end
    endtask

    task automatic check_exact(input string name, input logic [63:0] got,
                               input logic [63:0] want);
        assert (got === want) else begin
            $display("mismatch %s: got %h expected %h", name, got, want);
            fail_run();
        end
    endtask

    task automatic next_random(output tau_pkg::sample_t s);
        rng_state = xorshift(rng_state);
        // Sixteen signed bits give a magnitude below 0.5 in Q2.16
        s = tau_pkg::sample_t'($signed(rng_state[15:0]));
    endtask

    // Moves to 2 ns after the next rising edge and retires the slot of four cycles ago
    task automatic next_cycle();
        @(posedge clock);
        #2;
        cycle_count++;
        park_due[cycle_count % 4] = 1'b0;
        chain_due[cycle_count % 4] = 1'b0;
        sb_req = '0;
    endtask

    task automatic bus_write(input logic [31:0] address, input logic [31:0] data);
        next_cycle();
        sb_req.write_strobe = 1'b1;
        sb_req.address = address;
        sb_req.write_data = data;
        next_cycle();
    endtask

    task automatic bus_read(input logic [31:0] address, input logic valid,
                            input logic [31:0] data);
        next_cycle();
        sb_req.read_strobe = 1'b1;
        sb_req.address = address;
        next_cycle();
        check_exact("sb_rsp.read_valid", 64'(sb_rsp.read_valid), 64'(valid));
        if (valid) begin
            check_exact("sb_rsp.read_data", 64'(sb_rsp.read_data), 64'(data));
        end
    endtask

    // Drives one random vector and records what both rotations must give
    task automatic apply_vector();
        tau_pkg::sample_t s [9];
        real sn;
        real cs;
        real in_alpha;
        real in_beta;
        real inv_alpha;
        real inv_beta;
        int slot;
        next_cycle();
        for (int i = 0; i < 9; i++) begin
            next_random(s[i]);
        end
        rng_state = xorshift(rng_state);
        theta = {rng_state[7:0], 8'h00};
        clarke_in = '{c: s[2], b: s[1], a: s[0]};
        park_in = '{beta: s[4], alpha: s[3]};
        inverse_park_in = '{q: s[6], d: s[5]};
        inverse_clarke_in = '{beta: s[8], alpha: s[7]};
        sn = $sin(2.0 * pi * $itor(theta[15:8]) / 256.0);
        cs = $cos(2.0 * pi * $itor(theta[15:8]) / 256.0);
        if (direct_off) begin
            in_alpha = q2r(s[3]);
            in_beta = q2r(s[4]);
        end else begin
            in_alpha = clarke_alpha(q2r(s[0]), q2r(s[1]), q2r(s[2]));
            in_beta = clarke_beta(q2r(s[1]), q2r(s[2]));
        end
        slot = cycle_count % 4;
        exp_d[slot] = in_alpha * cs + in_beta * sn;
        exp_q[slot] = in_beta * cs - in_alpha * sn;
        park_due[slot] = 1'b1;
        inv_alpha = q2r(s[5]) * cs - q2r(s[6]) * sn;
        inv_beta = q2r(s[5]) * sn + q2r(s[6]) * cs;
        exp_a[slot] = inv_alpha;
        exp_beta[slot] = inv_beta;
        exp_b[slot] = phase_b(inv_alpha, inv_beta);
        exp_c[slot] = phase_c(inv_alpha, inv_beta);
        chain_due[slot] = 1'b1;
    endtask

    // Outputs are checked mid-cycle when every one of them has settled
    always @(negedge clock) begin
        int slot;
        if (dut.checks.failures != 0) begin
            $display("a bound assertion on the DUT failed");
            fail_run();
        end
        if (rst_n) begin
            check_near("clarke_out.alpha", clarke_out.alpha,
                       clarke_alpha(q2r(clarke_in.a), q2r(clarke_in.b), q2r(clarke_in.c)));
            check_near("clarke_out.beta", clarke_out.beta,
                       clarke_beta(q2r(clarke_in.b), q2r(clarke_in.c)));
            if (inverse_off) begin
                check_near("inverse_clarke_out.a", inverse_clarke_out.a,
                           q2r(inverse_clarke_in.alpha));
                check_near("inverse_clarke_out.b", inverse_clarke_out.b,
                           phase_b(q2r(inverse_clarke_in.alpha), q2r(inverse_clarke_in.beta)));
                check_near("inverse_clarke_out.c", inverse_clarke_out.c,
                           phase_c(q2r(inverse_clarke_in.alpha), q2r(inverse_clarke_in.beta)));
            end
            // Slot of the vector driven two cycles ago
            slot = (cycle_count + 2) % 4;
            if (park_due[slot]) begin
                check_near("park_out.d", park_out.d, exp_d[slot]);
                check_near("park_out.q", park_out.q, exp_q[slot]);
            end
            // The inverse rotation runs whatever the state of the inverse chain bit
            if (chain_due[slot]) begin
                check_near("inverse_park_out.alpha", inverse_park_out.alpha, exp_a[slot]);
                check_near("inverse_park_out.beta", inverse_park_out.beta, exp_beta[slot]);
                if (!inverse_off) begin
                    check_near("inverse_clarke_out.a", inverse_clarke_out.a, exp_a[slot]);
                    check_near("inverse_clarke_out.b", inverse_clarke_out.b, exp_b[slot]);
                    check_near("inverse_clarke_out.c", inverse_clarke_out.c, exp_c[slot]);
                end
            end
        end
    end

    initial begin
        rst_n = 1'b0;
        sb_req = '0;
        theta = '0;
        clarke_in = '0;
        park_in = '0;
        inverse_park_in = '0;
        inverse_clarke_in = '0;
        direct_off = 1'b0;
        inverse_off = 1'b0;
        repeat (4) @(posedge clock);
        #2;
        rst_n = 1'b1;

        // Everything starts cleared
        check_exact("park_out", 64'(park_out), 64'd0);
        check_exact("inverse_park_out", 64'(inverse_park_out), 64'd0);
        bus_read(base + tau_pkg::REG_CONTROL, 1'b1, 32'd0);

        // Both chains enabled with vectors applied back to back
        repeat (vectors_per_test) apply_vector();

        // Park takes park_in once the direct chain is disabled
        bus_write(base + tau_pkg::REG_CONTROL, 32'd1);
        direct_off = 1'b1;
        bus_read(base + tau_pkg::REG_CONTROL, 1'b1, 32'd1);
        repeat (vectors_per_test) apply_vector();

        // Inverse Clarke takes inverse_clarke_in with bit 1 set
        bus_write(base + tau_pkg::REG_CONTROL, 32'd3);
        inverse_off = 1'b1;
        bus_read(base + tau_pkg::REG_CONTROL, 1'b1, 32'd3);
        // The write-only and spare offsets read zero even with both control bits set
        bus_read(base + tau_pkg::REG_SOFT_RESET, 1'b1, 32'd0);
        bus_read(base + 32'd8, 1'b1, 32'd0);
        repeat (vectors_per_test) apply_vector();

        // Soft reset in the middle of a stream with both chains enabled
        bus_write(base + tau_pkg::REG_CONTROL, 32'd0);
        direct_off = 1'b0;
        inverse_off = 1'b0;
        repeat (vectors_per_test) apply_vector();
        bus_write(base + tau_pkg::REG_SOFT_RESET, 32'd1);
        repeat (vectors_per_test) apply_vector();

        // Accesses outside the block are ignored and leave the control register alone
        bus_write(base + 32'h100, 32'd3);
        bus_write(base - 32'd4, 32'd3);
        bus_read(base + 32'h100, 1'b0, 32'd0);
        bus_read(base + tau_pkg::REG_CONTROL, 1'b1, 32'd0);
        repeat (3) next_cycle();

        if (dut.checks.failures != 0) begin
            $display("a bound assertion on the DUT failed");
            fail_run();
        end else begin
            $display("** PASS **");
            $finish;
        end
    end

endmodule

//--- verilog.f
src/tau_pkg.sv
src/clarke.sv
src/anti_clarke.sv
src/sin_cos_lut.sv
src/park.sv
src/anti_park.sv
src/tau_control_unit.sv
src/transform_accel_unit.sv
tb/tau_checker.sv
tb/tau_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Builds the testbench with Verilator, runs it and looks for the pass line in the log

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert --top-module tau_tb -f verilog.f; then
    echo "Verilator build failed"
    exit 1
fi

if ! ./obj_dir/Vtau_tb > sim.log 2>&1; then
    cat sim.log
    echo "Simulation ended with an error status"
    exit 1
fi
cat sim.log

if grep -qxF "** PASS **" sim.log; then
    exit 0
fi
echo "Pass line not found in sim.log"
exit 1
